//--- build.f
+incdir+source
source/pcomp_io_pkg.sv
source/baud_rate_gen.sv
source/uart.sv
source/rx_loader.sv
source/ram_arbiter.sv
source/data_ram.sv
source/pcomp_io.sv
dv/pcomp_io_props.sv
dv/pcomp_io_tb.sv

//--- Makefile
# Verilator build for the pcomp i/o subsystem testbench

VERILATOR ?= verilator
TOP ?= pcomp_io_tb
CLOCK_FREQ ?= 3686400
BAUD_RATE ?= 115200
OBJ_DIR ?= obj_dir
FILELIST ?= build.f

VFLAGS ?= --binary --timing --assert
DEFINES = +define+PCOMP_CLOCK_FREQ=$(CLOCK_FREQ) +define+PCOMP_BAUD_RATE=$(BAUD_RATE)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(DEFINES) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the simulator's exit status is the verdict
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/pcomp_io_tb.sv
// pcomp i/o testbench: table-driven host ram, uart loopback and program load checks
`include "pcomp_io_macros.svh"

module pcomp_io_tb;

	// table operation kinds
	localparam int OP_MWR = 0;
	localparam int OP_MRD = 1;
	localparam int OP_UWR = 2;
	localparam int OP_URD = 3;
	localparam int OP_SEND = 4;
	localparam int OP_IDLE = 5;
	localparam int OP_RXPOP = 6;
	localparam int OP_RXFLUSH = 7;
	localparam int OP_LOAD = 8;
	localparam int OP_WAITLD = 9;

	// cycles per serial bit, from the same clock and baud as the dut
	localparam int DIV = `PCOMP_CLOCK_FREQ / (`PCOMP_BAUD_RATE * `PCOMP_OVERSAMPLE);
	localparam int BIT_CYCLES = ((DIV > 1) ? DIV : 1) * `PCOMP_OVERSAMPLE;
	localparam int FRAME_TO = 14 * BIT_CYCLES + 100;
	localparam int ACK_TO = 20;

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	logic irq;
	pcomp_io_pkg::uart_addr_t uart_addr;
	pcomp_io_pkg::word_t uart_wdata;
	logic uart_we;
	pcomp_io_pkg::word_t uart_rdata;
	logic mem_req;
	logic mem_we;
	pcomp_io_pkg::ram_addr_t mem_addr;
	pcomp_io_pkg::word_t mem_wdata;
	logic mem_ack;
	pcomp_io_pkg::word_t mem_rdata;
	logic load_start;
	pcomp_io_pkg::ram_addr_t load_base;
	logic [15:0] load_count;
	logic load_busy;

	// stimulus table columns
	int op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];
	// host view of ram contents
	pcomp_io_pkg::word_t shadow [`PCOMP_RAM_DEPTH];
	pcomp_io_pkg::byte_t rxq[$];
	logic bg_on;
	logic bg_busy;
	pcomp_io_pkg::ram_addr_t bg_addr;

	// serial loopback
	assign rx = tx;

	pcomp_io i_pcomp_io (
		.clk(clk), .rst(rst), .rx(rx), .tx(tx), .irq(irq),
		.uart_addr(uart_addr), .uart_wdata(uart_wdata), .uart_we(uart_we),
		.uart_rdata(uart_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.load_start(load_start), .load_base(load_base), .load_count(load_count),
		.load_busy(load_busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// collect every received byte, mid-cycle
	always @(negedge clk) begin
		if (!rst && irq) rxq.push_back(i_pcomp_io.i_uart.rx_byte);
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input pcomp_io_pkg::word_t exp,
		input pcomp_io_pkg::word_t got);
		if (got !== exp) fail_now($sformatf("FAILED %s expected %h got %h", name, exp, got));
	endtask

	task automatic check_byte(input string name, input pcomp_io_pkg::byte_t exp,
		input pcomp_io_pkg::byte_t got);
		if (got !== exp) fail_now($sformatf("FAILED %s expected %h got %h", name, exp, got));
	endtask

	task automatic add_row(input int op, input logic [31:0] a, input logic [31:0] d,
		input logic [31:0] e);
		op_q.push_back(op);
		addr_q.push_back(a);
		data_q.push_back(d);
		exp_q.push_back(e);
		if (op == OP_MWR) shadow[a[7:0]] = d;
	endtask

	// ack comes in the cycle after the grant, as the request drops
	task automatic wait_ack(input string what);
		int n;
		n = 0;
		while (!mem_ack) begin
			if (n >= ACK_TO) fail_now({"no mem_ack for host ", what});
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic mem_write(input pcomp_io_pkg::ram_addr_t a, input pcomp_io_pkg::word_t d);
		@(posedge clk);
		#1;
		mem_req = 1'b1;
		mem_we = 1'b1;
		mem_addr = a;
		mem_wdata = d;
		@(posedge clk);
		#1;
		mem_req = 1'b0;
		wait_ack("write");
	endtask

	task automatic mem_read(input pcomp_io_pkg::ram_addr_t a, output pcomp_io_pkg::word_t d);
		@(posedge clk);
		#1;
		mem_req = 1'b1;
		mem_we = 1'b0;
		mem_addr = a;
		@(posedge clk);
		#1;
		mem_req = 1'b0;
		wait_ack("read");
		d = mem_rdata;
	endtask

	task automatic uart_write(input pcomp_io_pkg::uart_addr_t a, input pcomp_io_pkg::word_t d);
		@(posedge clk);
		#1;
		uart_addr = a;
		uart_wdata = d;
		uart_we = 1'b1;
		@(posedge clk);
		#1;
		uart_we = 1'b0;
	endtask

	// rdata is combinational, sampled mid-cycle
	task automatic uart_read(input pcomp_io_pkg::uart_addr_t a, output pcomp_io_pkg::word_t d);
		@(posedge clk);
		#1;
		uart_addr = a;
		@(negedge clk);
		d = uart_rdata;
	endtask

	task automatic poll_tx_idle();
		pcomp_io_pkg::word_t got;
		int n;
		n = 0;
		uart_read(`PCOMP_UART_TXIDLE, got);
		while (got !== 32'h0100_0000) begin
			if (n >= FRAME_TO) fail_now("transmitter never returned to idle");
			uart_read(`PCOMP_UART_TXIDLE, got);
			n++;
		end
	endtask

	task automatic start_load(input pcomp_io_pkg::ram_addr_t base, input logic [15:0] count);
		@(posedge clk);
		#1;
		load_start = 1'b1;
		load_base = base;
		load_count = count;
		@(posedge clk);
		#1;
		load_start = 1'b0;
	endtask

	task automatic pop_rx(input pcomp_io_pkg::byte_t exp);
		int n;
		n = 0;
		while (rxq.size() == 0) begin
			if (n >= 4 * FRAME_TO) fail_now("no byte received on the loopback");
			@(posedge clk);
			n++;
		end
		check_byte("rx_byte", exp, rxq.pop_front());
	endtask

	task automatic wait_load_done();
		int n;
		n = 0;
		while (load_busy || bg_busy) begin
			if (n >= 2 * FRAME_TO) fail_now("load_busy never fell after the load");
			@(posedge clk);
			#1;
			n++;
			if (!load_busy) bg_on = 1'b0;
		end
		bg_on = 1'b0;
	endtask

	// host reads of the preloaded block while the loader runs
	initial begin
		pcomp_io_pkg::word_t got;
		bg_busy = 1'b0;
		bg_addr = 8'h40;
		forever begin
			@(posedge clk);
			if (bg_on) begin
				bg_busy = 1'b1;
				mem_read(bg_addr, got);
				check_word("mem_rdata", shadow[bg_addr], got);
				bg_addr = (bg_addr == 8'h47) ? 8'h40 : bg_addr + 1'b1;
				bg_busy = 1'b0;
			end
		end
	end

	// one load sequence: start, seven bytes, wait, read two packed words
	task automatic add_load(input logic [7:0] base, input logic busy_host);
		pcomp_io_pkg::byte_t b [7];
		for (int i = 0; i < 7; i++) b[i] = 8'($urandom);
		add_row(OP_LOAD, base, 32'd7, {31'h0, busy_host});
		for (int i = 0; i < 7; i++) add_row(OP_SEND, 0, {b[i], 24'h0}, 0);
		add_row(OP_WAITLD, 0, 0, 0);
		add_row(OP_RXFLUSH, 0, 0, 0);
		// little-endian, top lane of the tail word zero
		add_row(OP_MRD, base, 0, {b[3], b[2], b[1], b[0]});
		add_row(OP_MRD, base + 8'd1, 0, {8'h00, b[6], b[5], b[4]});
	endtask

	initial begin
		pcomp_io_pkg::word_t got;
		pcomp_io_pkg::byte_t ub;
		pcomp_io_pkg::byte_t bb [3];
		logic [31:0] w;
		rst = 1'b1;
		uart_addr = '0;
		uart_wdata = '0;
		uart_we = 1'b0;
		mem_req = 1'b0;
		mem_we = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		load_start = 1'b0;
		load_base = '0;
		load_count = '0;
		bg_on = 1'b0;
		void'($urandom(32'h3af4770b));

		// flags straight out of reset: no new data, transmitter idle
		add_row(OP_URD, `PCOMP_UART_RXNEW, 0, 32'h0);
		add_row(OP_URD, `PCOMP_UART_TXIDLE, 0, 32'h0100_0000);
		// host ram round trip, plus the block read during contention
		for (int i = 0; i < 8; i++) begin
			w = $urandom;
			add_row(OP_MWR, 8'h40 + i, w, 0);
		end
		for (int i = 0; i < 8; i++) add_row(OP_MRD, 8'h40 + i, 0, shadow[8'h40 + i]);
		// uart loopback and flags
		ub = 8'($urandom);
		add_row(OP_UWR, `PCOMP_UART_DATA, {ub, 24'h0}, 0);
		add_row(OP_URD, `PCOMP_UART_TXIDLE, 0, 32'h0);
		add_row(OP_RXPOP, 0, 0, ub);
		add_row(OP_URD, `PCOMP_UART_DATA, 0, {ub, 24'h0});
		add_row(OP_URD, `PCOMP_UART_RXNEW, 0, 32'h0100_0000);
		add_row(OP_UWR, `PCOMP_UART_RXNEW, 0, 0);
		add_row(OP_URD, `PCOMP_UART_RXNEW, 0, 32'h0);
		add_row(OP_IDLE, 0, 0, 0);
		// back-to-back bytes arrive in order
		for (int i = 0; i < 3; i++) bb[i] = 8'($urandom);
		for (int i = 0; i < 3; i++) add_row(OP_SEND, 0, {bb[i], 24'h0}, 0);
		for (int i = 0; i < 3; i++) add_row(OP_RXPOP, 0, 0, bb[i]);
		// quiet load, then one under host traffic
		add_load(8'h10, 1'b0);
		add_load(8'h20, 1'b1);
		for (int i = 0; i < 8; i++) add_row(OP_MRD, 8'h40 + i, 0, shadow[8'h40 + i]);

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int r = 0; r < op_q.size(); r++) begin
			case (op_q[r])
				OP_MWR: mem_write(addr_q[r][7:0], data_q[r]);
				OP_MRD: begin
					mem_read(addr_q[r][7:0], got);
					check_word("mem_rdata", exp_q[r], got);
				end
				OP_UWR: uart_write(addr_q[r][2:0], data_q[r]);
				OP_URD: begin
					uart_read(addr_q[r][2:0], got);
					check_word("uart_rdata", exp_q[r], got);
				end
				OP_SEND: begin
					poll_tx_idle();
					uart_write(`PCOMP_UART_DATA, data_q[r]);
				end
				OP_IDLE: poll_tx_idle();
				OP_RXPOP: pop_rx(exp_q[r][7:0]);
				OP_RXFLUSH: rxq.delete();
				OP_LOAD: begin
					start_load(addr_q[r][7:0], data_q[r][15:0]);
					// expected column flags host traffic during the load
					bg_on = exp_q[r][0];
				end
				OP_WAITLD: wait_load_done();
				default: fail_now("unknown operation in the stimulus table");
			endcase
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- dv/pcomp_io_props.sv
// pcomp i/o control properties: grant exclusion, ack timing, receive pulse, tx idle, loader hold
module pcomp_io_props (
	input logic                clk,
	input logic                rst,
	input logic                host_gnt,
	input logic                ldr_req,
	input logic                ldr_gnt,
	input pcomp_io_pkg::word_t ldr_wdata,
	input logic                mem_ack,
	input logic                rx_pulse,
	input logic                tx,
	input logic                tx_idle
);

	// one owner of the ram port per cycle
	a_one_grant: assert property (@(posedge clk) disable iff (rst) !(host_gnt && ldr_gnt))
		else $error("host and loader granted together");

	// ack exactly one cycle after a host grant
	a_ack_after: assert property (@(posedge clk) disable iff (rst) host_gnt |=> mem_ack)
		else $error("mem_ack missing after host grant");
	a_ack_cause: assert property (@(posedge clk) disable iff (rst) mem_ack |-> $past(host_gnt))
		else $error("mem_ack without a host grant");

	// receive pulse is a single cycle
	a_pulse: assert property (@(posedge clk) disable iff (rst) rx_pulse |=> !rx_pulse)
		else $error("rx_pulse high for two cycles");

	// line idles high
	a_tx_idle: assert property (@(posedge clk) disable iff (rst) tx_idle |-> tx)
		else $error("tx low while transmitter idle");

	// next packed word never lands on a write still waiting for the port
	a_ldr_wait: assert property (@(posedge clk) disable iff (rst)
		(ldr_req && !ldr_gnt) |=> $stable(ldr_wdata))
		else $error("loader word replaced while its write was pending");

	// request drops right after its grant, no new word in the grant cycle
	a_ldr_clear: assert property (@(posedge clk) disable iff (rst) ldr_gnt |=> !ldr_req)
		else $error("loader request raised again while the previous one was pending");

endmodule

bind ram_arbiter pcomp_io_props i_arb_props (
	.clk(clk), .rst(rst), .host_gnt(host_gnt), .ldr_req(ldr_req), .ldr_gnt(ldr_gnt),
	.ldr_wdata(ldr_wdata), .mem_ack(mem_ack), .rx_pulse(1'b0), .tx(1'b1), .tx_idle(1'b0)
);

bind uart pcomp_io_props i_uart_props (
	.clk(clk), .rst(rst), .host_gnt(1'b0), .ldr_req(1'b0), .ldr_gnt(1'b0),
	.ldr_wdata(32'h0), .mem_ack(1'b0), .rx_pulse(rx_pulse), .tx(tx), .tx_idle(tx_idle)
);

//--- source/pcomp_io.sv
// pcomp i/o top: uart, baud generator, serial loader, ram arbiter and shared data ram
`include "pcomp_io_macros.svh"

module pcomp_io (
	input  logic                     clk,
	input  logic                     rst,
	// serial line and receive interrupt
	input  logic                     rx,
	output logic                     tx,
	output logic                     irq,
	// uart registers
	input  pcomp_io_pkg::uart_addr_t uart_addr,
	input  pcomp_io_pkg::word_t      uart_wdata,
	input  logic                     uart_we,
	output pcomp_io_pkg::word_t      uart_rdata,
	// host ram port
	input  logic                     mem_req,
	input  logic                     mem_we,
	input  pcomp_io_pkg::ram_addr_t  mem_addr,
	input  pcomp_io_pkg::word_t      mem_wdata,
	output logic                     mem_ack,
	output pcomp_io_pkg::word_t      mem_rdata,
	// loader control
	input  logic                     load_start,
	input  pcomp_io_pkg::ram_addr_t  load_base,
	input  logic [15:0]              load_count,
	output logic                     load_busy
);

	logic sample_en;
	logic bit_en;
	logic rx_pulse;
	pcomp_io_pkg::byte_t rx_byte;
	logic ldr_req;
	logic ldr_gnt;
	pcomp_io_pkg::ram_addr_t ldr_addr;
	pcomp_io_pkg::word_t ldr_wdata;
	logic ram_en;
	logic ram_we;
	pcomp_io_pkg::ram_addr_t ram_addr;
	pcomp_io_pkg::word_t ram_wdata;
	pcomp_io_pkg::word_t ram_rdata;

	// receive pulse doubles as the cpu interrupt
	assign irq = rx_pulse;

	baud_rate_gen #(
		.CLOCK_FREQ(`PCOMP_CLOCK_FREQ),
		.BAUD_RATE (`PCOMP_BAUD_RATE)
	) i_baud_rate_gen (
		.clk      (clk),
		.rst      (rst),
		.sample_en(sample_en),
		.bit_en   (bit_en)
	);

	uart i_uart (
		.clk      (clk),
		.rst      (rst),
		.sample_en(sample_en),
		.bit_en   (bit_en),
		.rx       (rx),
		.tx       (tx),
		.addr     (uart_addr),
		.wdata    (uart_wdata),
		.we       (uart_we),
		.rdata    (uart_rdata),
		.rx_pulse (rx_pulse),
		.rx_byte  (rx_byte)
	);

	rx_loader i_rx_loader (
		.clk       (clk),
		.rst       (rst),
		.load_start(load_start),
		.load_base (load_base),
		.load_count(load_count),
		.rx_pulse  (rx_pulse),
		.rx_byte   (rx_byte),
		.load_busy (load_busy),
		.ldr_req   (ldr_req),
		.ldr_addr  (ldr_addr),
		.ldr_wdata (ldr_wdata),
		.ldr_gnt   (ldr_gnt)
	);

	ram_arbiter i_ram_arbiter (
		.clk      (clk),
		.rst      (rst),
		.mem_req  (mem_req),
		.mem_we   (mem_we),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack  (mem_ack),
		.mem_rdata(mem_rdata),
		.ldr_req  (ldr_req),
		.ldr_addr (ldr_addr),
		.ldr_wdata(ldr_wdata),
		.ldr_gnt  (ldr_gnt),
		.ram_en   (ram_en),
		.ram_we   (ram_we),
		.ram_addr (ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	data_ram i_data_ram (
		.clk  (clk),
		.en   (ram_en),
		.we   (ram_we),
		.addr (ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

endmodule

//--- source/data_ram.sv
// single-port synchronous word ram with one-cycle registered read
`include "pcomp_io_macros.svh"

module data_ram (
	input  logic                    clk,
	input  logic                    en,
	input  logic                    we,
	input  pcomp_io_pkg::ram_addr_t addr,
	input  pcomp_io_pkg::word_t     wdata,
	output pcomp_io_pkg::word_t     rdata
);

	pcomp_io_pkg::word_t mem [`PCOMP_RAM_DEPTH];

	// write or read, never both on one access
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) mem[addr] <= wdata;
			// rdata holds across writes and idle cycles
			else rdata <= mem[addr];
		end
	end

endmodule

//--- source/ram_arbiter.sv
// fixed-priority ram arbiter: host first, loader otherwise, with host ack and read return
module ram_arbiter (
	input  logic                    clk,
	input  logic                    rst,
	// host load/store port
	input  logic                    mem_req,
	input  logic                    mem_we,
	input  pcomp_io_pkg::ram_addr_t mem_addr,
	input  pcomp_io_pkg::word_t     mem_wdata,
	output logic                    mem_ack,
	output pcomp_io_pkg::word_t     mem_rdata,
	// loader, write only
	input  logic                    ldr_req,
	input  pcomp_io_pkg::ram_addr_t ldr_addr,
	input  pcomp_io_pkg::word_t     ldr_wdata,
	output logic                    ldr_gnt,
	// single ram port
	output logic                    ram_en,
	output logic                    ram_we,
	output pcomp_io_pkg::ram_addr_t ram_addr,
	output pcomp_io_pkg::word_t     ram_wdata,
	input  pcomp_io_pkg::word_t     ram_rdata
);

	logic host_gnt;
	logic host_gnt_q;

	// host wins any cycle it asks
	assign host_gnt = mem_req;
	assign ldr_gnt = ldr_req && !mem_req;

	// granted request drives the ram in the same cycle
	assign ram_en = host_gnt || ldr_gnt;
	assign ram_we = host_gnt ? mem_we : 1'b1;
	assign ram_addr = host_gnt ? mem_addr : ldr_addr;
	assign ram_wdata = host_gnt ? mem_wdata : ldr_wdata;

	// ack lines up with the ram read latency
	always_ff @(posedge clk) begin
		if (rst) host_gnt_q <= 1'b0;
		else host_gnt_q <= host_gnt;
	end

	assign mem_ack = host_gnt_q;
	// read data only presented in the ack cycle
	assign mem_rdata = host_gnt_q ? ram_rdata : '0;

endmodule

//--- source/rx_loader.sv
// serial program loader: packs received bytes little-endian into words and writes them to ram
module rx_loader (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    load_start,
	input  pcomp_io_pkg::ram_addr_t load_base,
	input  logic [15:0]             load_count,
	input  logic                    rx_pulse,
	input  pcomp_io_pkg::byte_t     rx_byte,
	output logic                    load_busy,
	output logic                    ldr_req,
	output pcomp_io_pkg::ram_addr_t ldr_addr,
	output pcomp_io_pkg::word_t     ldr_wdata,
	input  logic                    ldr_gnt
);

	logic [15:0] remaining;
	logic [1:0] lane;
	logic last_word;
	pcomp_io_pkg::word_t pack_word;
	pcomp_io_pkg::word_t pack_next;
	logic byte_in;
	logic word_full;

	assign byte_in = load_busy && rx_pulse;
	// fourth lane filled, or the final counted byte
	assign word_full = (lane == 2'd3) || (remaining == 16'd1);

	// drop the new byte into its lane
	always_comb begin
		pack_next = pack_word;
		pack_next[{lane, 3'b000} +: 8] = rx_byte;
	end

	// control: byte count, lane, request and address
	always_ff @(posedge clk) begin
		if (rst) begin
			load_busy <= 1'b0;
			ldr_req <= 1'b0;
			last_word <= 1'b0;
			lane <= '0;
			remaining <= '0;
			ldr_addr <= '0;
		end else begin
			if (load_start && !load_busy) begin
				load_busy <= (load_count != 16'd0);
				remaining <= load_count;
				lane <= '0;
				ldr_addr <= load_base;
			end
			// granted write, step the address
			if (ldr_gnt) begin
				ldr_req <= 1'b0;
				ldr_addr <= ldr_addr + 1'b1;
				if (last_word) begin
					load_busy <= 1'b0;
					last_word <= 1'b0;
				end
			end
			if (byte_in) begin
				remaining <= remaining - 1'b1;
				lane <= word_full ? 2'd0 : lane + 1'b1;
				if (word_full) ldr_req <= 1'b1;
				if (remaining == 16'd1) last_word <= 1'b1;
			end
		end
	end

	// payload: unused lanes stay zero since the packer restarts clear
	always_ff @(posedge clk) begin
		if (load_start && !load_busy) pack_word <= '0;
		else if (byte_in) pack_word <= word_full ? '0 : pack_next;
		if (byte_in && word_full) ldr_wdata <= pack_next;
	end

endmodule

//--- source/uart.sv
// memory-mapped uart: 8n1 transmitter, oversampling receiver, status flags, receive pulse
`include "pcomp_io_macros.svh"

module uart (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     sample_en,
	input  logic                     bit_en,
	input  logic                     rx,
	output logic                     tx,
	input  pcomp_io_pkg::uart_addr_t addr,
	input  pcomp_io_pkg::word_t      wdata,
	input  logic                     we,
	output pcomp_io_pkg::word_t      rdata,
	output logic                     rx_pulse,
	output pcomp_io_pkg::byte_t      rx_byte
);

	// receive timing, in samples within one bit
	localparam int SMP_W = $clog2(`PCOMP_OVERSAMPLE);
	localparam int SAMPLE_COUNT = `PCOMP_OVERSAMPLE - 1;
	// roughly a third into the bit
	localparam int SAMPLE_POINT = `PCOMP_OVERSAMPLE * 5 / 16;
	// earliest point in the stop bit where a new start edge is trusted
	localparam int SAMPLE_REMEDY = `PCOMP_OVERSAMPLE / 6;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
	typedef enum logic [1:0] {RX_START, RX_REMEDY, RX_DATA, RX_STOP} rx_state_t;

	tx_state_t tx_state;
	logic [3:0] tx_cnt;
	pcomp_io_pkg::byte_t tx_data;
	logic tx_write;
	logic tx_idle;

	logic rx_r;
	rx_state_t rx_state;
	logic [SMP_W-1:0] rx_sample;
	logic [3:0] rx_bitpos;
	pcomp_io_pkg::byte_t rx_scratch;
	logic rx_take;
	logic rx_done;
	logic rx_new;

	// data write only starts a frame from idle
	assign tx_write = we && (addr == `PCOMP_UART_DATA) && (tx_state == TX_IDLE);
	assign tx_idle = (tx_state == TX_IDLE);

	// transmitter fsm
	// data state sends bits 0..7, then raises the line for the stop bit
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx <= 1'b1;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (tx_write) begin
						tx_state <= TX_START;
						tx_cnt <= '0;
					end
				end
				TX_START: begin
					if (bit_en) begin
						tx <= 1'b0;
						tx_state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_en) begin
						if (tx_cnt == 4'd8) begin
							tx <= 1'b1;
							tx_state <= TX_STOP;
						end else begin
							// lsb first
							tx <= tx_data[tx_cnt[2:0]];
							tx_cnt <= tx_cnt + 1'b1;
						end
					end
				end
				TX_STOP: begin
					// hold the stop bit for one full period
					if (bit_en) tx_state <= TX_IDLE;
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// byte to send lives in the top lane of the bus word
	always_ff @(posedge clk) begin
		if (tx_write) tx_data <= wdata[31:24];
	end

	// single-register synchronizer, idles high
	always_ff @(posedge clk) begin
		if (rst) rx_r <= 1'b1;
		else rx_r <= rx;
	end

	assign rx_take = sample_en && (rx_state == RX_DATA) && (rx_sample == SMP_W'(SAMPLE_POINT));
	// stop bit ends at its last sample, or early on a new start edge
	assign rx_done = sample_en && (rx_state == RX_STOP) &&
		((rx_sample == SMP_W'(SAMPLE_COUNT)) || ((rx_sample >= SMP_W'(SAMPLE_REMEDY)) && !rx_r));

	// receiver fsm
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_state <= RX_START;
			rx_sample <= '0;
			rx_bitpos <= '0;
		end else if (sample_en) begin
			case (rx_state)
				RX_START: begin
					// wait for the falling edge, then count through the start bit
					if (!rx_r || rx_sample != '0) rx_sample <= rx_sample + 1'b1;
					if (rx_sample == SMP_W'(SAMPLE_COUNT)) begin
						rx_state <= RX_DATA;
						rx_bitpos <= '0;
						rx_sample <= '0;
					end
				end
				RX_REMEDY: begin
					// start edge already seen in the stop bit
					rx_sample <= rx_sample + 1'b1;
					if (rx_sample == SMP_W'(SAMPLE_COUNT)) begin
						rx_state <= RX_DATA;
						rx_bitpos <= '0;
						rx_sample <= '0;
					end
				end
				RX_DATA: begin
					if (rx_sample == SMP_W'(SAMPLE_COUNT)) rx_sample <= '0;
					else rx_sample <= rx_sample + 1'b1;
					if (rx_take) rx_bitpos <= rx_bitpos + 1'b1;
					if (rx_bitpos == 4'd8 && rx_sample == SMP_W'(SAMPLE_COUNT)) rx_state <= RX_STOP;
				end
				RX_STOP: begin
					if (rx_done) begin
						rx_state <= rx_r ? RX_START : RX_REMEDY;
						rx_sample <= '0;
					end else begin
						rx_sample <= rx_sample + 1'b1;
					end
				end
				default: rx_state <= RX_START;
			endcase
		end
	end

	// shift in data bits, publish the byte at the stop bit
	always_ff @(posedge clk) begin
		if (rx_take) rx_scratch[rx_bitpos[2:0]] <= rx_r;
		if (rx_done) rx_byte <= rx_scratch;
	end

	// new-data flag, a completing byte beats the clear
	always_ff @(posedge clk) begin
		if (rst) rx_new <= 1'b0;
		else if (rx_done) rx_new <= 1'b1;
		else if (we && addr == `PCOMP_UART_RXNEW) rx_new <= 1'b0;
	end

	// one-cycle pulse after the byte lands
	always_ff @(posedge clk) begin
		if (rst) rx_pulse <= 1'b0;
		else rx_pulse <= rx_done;
	end

	// register read mux, flags in bit 24
	always_comb begin
		case (addr)
			`PCOMP_UART_DATA: rdata = {rx_byte, 24'h0};
			`PCOMP_UART_RXNEW: rdata = {7'h0, rx_new, 24'h0};
			`PCOMP_UART_TXIDLE: rdata = {7'h0, tx_idle, 24'h0};
			default: rdata = '0;
		endcase
	end

endmodule

//--- source/baud_rate_gen.sv
// baud rate generator: receive sample enable at oversampled rate, transmit bit enable
`include "pcomp_io_macros.svh"

module baud_rate_gen #(
	parameter int CLOCK_FREQ = `PCOMP_CLOCK_FREQ,
	parameter int BAUD_RATE = `PCOMP_BAUD_RATE
) (
	input  logic clk,
	input  logic rst,
	output logic sample_en,
	output logic bit_en
);

	// clocks per receive sample, truncated
	localparam int SAMPLE_DIV = CLOCK_FREQ / (BAUD_RATE * `PCOMP_OVERSAMPLE);
	localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int SMP_W = $clog2(`PCOMP_OVERSAMPLE);

	logic [DIV_W-1:0] div_cnt;
	logic [SMP_W-1:0] smp_cnt;

	// clock divider for the sample enable
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			sample_en <= 1'b0;
		end else if (div_cnt == DIV_W'(SAMPLE_DIV - 1)) begin
			div_cnt <= '0;
			sample_en <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			sample_en <= 1'b0;
		end
	end

	// one bit enable every oversample count of sample enables
	always_ff @(posedge clk) begin
		if (rst) begin
			smp_cnt <= '0;
			bit_en <= 1'b0;
		end else begin
			bit_en <= 1'b0;
			if (sample_en) begin
				if (smp_cnt == SMP_W'(`PCOMP_OVERSAMPLE - 1)) begin
					smp_cnt <= '0;
					bit_en <= 1'b1;
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- source/pcomp_io_pkg.sv
// pcomp i/o shared types for bus words, serial bytes and register addresses
`include "pcomp_io_macros.svh"

package pcomp_io_pkg;

	// host bus and ram data word
	typedef logic [31:0] word_t;

	// one serial byte
	typedef logic [7:0] byte_t;

	// ram word address, sized from the ram depth
	typedef logic [$clog2(`PCOMP_RAM_DEPTH)-1:0] ram_addr_t;

	// uart register select
	// only offsets 0..2 decode, the rest read as zero
	typedef logic [2:0] uart_addr_t;

endpackage

//--- source/pcomp_io_macros.svh
// pcomp i/o subsystem macros: clock, baud rate, oversampling, ram size and uart offsets
`ifndef PCOMP_IO_MACROS_SVH
`define PCOMP_IO_MACROS_SVH

// system clock in hz
`define PCOMP_CLOCK_FREQ 62500000

// serial bit rate
`define PCOMP_BAUD_RATE 115200

// receive samples per serial bit
`define PCOMP_OVERSAMPLE 32

// shared data ram size in words
`define PCOMP_RAM_DEPTH 256

// uart register offsets, word index on the host bus
`define PCOMP_UART_DATA 3'd0
`define PCOMP_UART_RXNEW 3'd1
`define PCOMP_UART_TXIDLE 3'd2

`endif
